// File: run_sim.sh
#!/bin/sh
# Build and run the leaf testbench with Verilator.
# The exit status is nonzero when the testbench fails.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_leaf_i1o2 \
    -f sources.f \
    -o sim_tb_leaf_i1o2

./obj_dir/sim_tb_leaf_i1o2

// File: sim/tb_leaf_i1o2.sv
`timescale 1ns/10ps
module tb_leaf_i1o2;

    localparam int LEAF_ID    = 5;
    localparam int FIFO_DEPTH = 8;
    localparam int GROUP_SIZE = 4;
    localparam int N_BASIC    = 16;
    localparam int N_JUNK     = 6;
    localparam int N_RESEND   = 24;
    localparam int N_REDIRECT = 12;
    localparam int N_CFG      = 4;
    localparam int N_STIM     = N_BASIC + N_JUNK + N_RESEND + N_REDIRECT + N_CFG;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             resend;
    bft_pkg::packet_t din;
    bft_pkg::packet_t dout;

    // model of the destination table, address counters and group sum.
    logic [bft_pkg::NUM_LEAF_BITS-1:0] dst_leaf_m [2];
    logic [bft_pkg::NUM_PORT_BITS-1:0] dst_port_m [2];
    logic [bft_pkg::NUM_ADDR_BITS-1:0] addr_m [2];
    logic [31:0]                       acc_m;
    int                                grp_m;

    bft_pkg::packet_t exp_q1 [$];
    bft_pkg::packet_t exp_q2 [$];

    always #2 clk = ~clk;

    leaf_i1o2 #(
        .LEAF_ID    (LEAF_ID),
        .FIFO_DEPTH (FIFO_DEPTH),
        .GROUP_SIZE (GROUP_SIZE)
    ) leaf_i1o2_inst (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend)
    );

    // byte order of the word turned around.
    function automatic logic [31:0] expected_word(input logic [31:0] w);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s expected 0x%0h got 0x%0h", name, expected, actual));
        end
    endtask

    task automatic push_expected(input int idx, input logic [31:0] payload);
        bft_pkg::packet_t p;
        p.data.valid    = 1'b1;
        p.data.dst_leaf = dst_leaf_m[idx];
        p.data.dst_port = dst_port_m[idx];
        p.data.addr     = addr_m[idx];
        p.data.payload  = payload;
        addr_m[idx]     = addr_m[idx] + 1'b1;
        if (idx == 0) begin
            exp_q1.push_back(p);
        end else begin
            exp_q2.push_back(p);
        end
    endtask

    // called on a falling edge, the word is present for one cycle.
    task automatic drive_word(input bft_pkg::packet_t p, input int gap);
        din = p;
        @(negedge clk);
        din = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_data(input logic [31:0] value);
        bft_pkg::packet_t p;
        p.data.valid    = 1'b1;
        p.data.dst_leaf = 5'(LEAF_ID);
        p.data.dst_port = 4'd2;
        p.data.addr     = 7'($urandom);
        p.data.payload  = value;
        push_expected(0, expected_word(value));
        acc_m = acc_m + value;
        grp_m = grp_m + 1;
        if (grp_m == GROUP_SIZE) begin
            push_expected(1, acc_m);
            acc_m = '0;
            grp_m = 0;
        end
        drive_word(p, 2);
    endtask

    task automatic send_cfg(input int sel, input logic [4:0] leaf, input logic [3:0] port);
        bft_pkg::packet_t p;
        p              = '0;
        p.cfg.valid    = 1'b1;
        p.cfg.dst_leaf = 5'(LEAF_ID);
        p.cfg.dst_port = 4'd0;
        p.cfg.cfg      = {19'd0, 4'(sel), leaf, port};
        dst_leaf_m[sel] = leaf;
        dst_port_m[sel] = port;
        drive_word(p, 2);
    endtask

    // other leaf, unknown port, valid bit clear, in turn.
    task automatic send_junk(input int count);
        bft_pkg::packet_t p;
        for (int i = 0; i < count; i++) begin
            p.data.valid    = 1'b1;
            p.data.dst_leaf = 5'(LEAF_ID);
            p.data.dst_port = 4'd2;
            p.data.addr     = 7'($urandom);
            p.data.payload  = $urandom;
            if (i % 3 == 0) begin
                p.data.dst_leaf = 5'(LEAF_ID) ^ 5'($urandom_range(1, 31));
            end else if (i % 3 == 1) begin
                p.data.dst_port = 4'($urandom_range(3, 15));
            end else begin
                p.data.valid = 1'b0;
            end
            drive_word(p, 2);
        end
    endtask

    task automatic hold_resend(input int cycles);
        resend = 1'b1;
        repeat (cycles) @(negedge clk);
        resend = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q1.size() + exp_q2.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
    endtask

    // output 1 is told apart by the destination it is configured for.
    always @(posedge clk) begin
        bft_pkg::packet_t exp_pkt;
        int               port_idx;
        if (rst_n === 1'b1) begin
            if (resend || !dout.data.valid) begin
                check_value("dout", 64'd0, 64'(dout));
            end else begin
                port_idx = (dout.data.dst_leaf == dst_leaf_m[0] &&
                            dout.data.dst_port == dst_port_m[0]) ? 1 : 2;
                if ((port_idx == 1 && exp_q1.size() == 0) ||
                    (port_idx == 2 && exp_q2.size() == 0)) begin
                    abort_run($sformatf("packet for output %0d arrived but none was expected",
                                        port_idx));
                end else begin
                    if (port_idx == 1) begin
                        exp_pkt = exp_q1.pop_front();
                    end else begin
                        exp_pkt = exp_q2.pop_front();
                    end
                    check_value("dst_leaf", 64'(exp_pkt.data.dst_leaf), 64'(dout.data.dst_leaf));
                    check_value("dst_port", 64'(exp_pkt.data.dst_port), 64'(dout.data.dst_port));
                    check_value("addr", 64'(exp_pkt.data.addr), 64'(dout.data.addr));
                    check_value("payload", 64'(exp_pkt.data.payload), 64'(dout.data.payload));
                end
            end
        end
    end

    initial begin
        repeat (N_STIM * 200 + 500) @(posedge clk);
        abort_run($sformatf("timeout with %0d expected packets still missing",
                            exp_q1.size() + exp_q2.size()));
    end

    initial begin
        void'($urandom(72));
        rst_n  = 1'b0;
        resend = 1'b0;
        din    = '0;
        for (int i = 0; i < 2; i++) begin
            dst_leaf_m[i] = 5'd0;
            dst_port_m[i] = 4'd2;
            addr_m[i]     = '0;
        end
        acc_m = '0;
        grp_m = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle leaf after reset.
        repeat (20) @(negedge clk);

        send_cfg(0, 5'd3, 4'd2);
        send_cfg(1, 5'd9, 4'd3);
        for (int i = 0; i < N_BASIC; i++) begin
            send_data($urandom);
        end
        send_junk(N_JUNK);
        wait_drain();

        for (int i = 0; i < N_RESEND; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                hold_resend($urandom_range(1, 20));
            end
            send_data($urandom);
        end
        hold_resend($urandom_range(1, 20));
        wait_drain();

        // new destinations only for packets formed from here on.
        send_cfg(0, 5'd17, 4'd6);
        send_cfg(1, 5'd3, 4'd2);
        for (int i = 0; i < N_REDIRECT; i++) begin
            send_data($urandom);
        end
        wait_drain();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sources.f
verilog/bft_pkg.sv
verilog/leaf_pkg.sv
verilog/sync_fifo.sv
verilog/leaf_rx.sv
verilog/user_kernel.sv
verilog/leaf_tx.sv
verilog/leaf_i1o2.sv
sim/tb_leaf_i1o2.sv

// File: verilog/bft_pkg.sv
package bft_pkg;

    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    // data packet as it travels through the tree.
    typedef struct packed {
        logic                     valid;
        logic [NUM_LEAF_BITS-1:0] dst_leaf;
        logic [NUM_PORT_BITS-1:0] dst_port;
        logic [NUM_ADDR_BITS-1:0] addr;
        logic [PAYLOAD_BITS-1:0]  payload;
    } data_pkt_t;

    // configuration packet, dst_port is always 0 and addr is unused.
    typedef struct packed {
        logic                     valid;
        logic [NUM_LEAF_BITS-1:0] dst_leaf;
        logic [NUM_PORT_BITS-1:0] dst_port;
        logic [NUM_ADDR_BITS-1:0] addr;
        logic [PAYLOAD_BITS-1:0]  cfg;
    } cfg_pkt_t;

    // one network word, read either way.
    typedef union packed {
        data_pkt_t data;
        cfg_pkt_t  cfg;
    } packet_t;

endpackage

// File: verilog/leaf_i1o2.sv
`timescale 1ns/10ps
module leaf_i1o2 #(
    parameter int LEAF_ID    = 5,
    parameter int FIFO_DEPTH = 8,
    parameter int GROUP_SIZE = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [bft_pkg::PACKET_BITS-1:0]  din_leaf_bft2interface,
    output logic [bft_pkg::PACKET_BITS-1:0]  dout_leaf_interface2bft,
    input  logic                             resend
);

    logic [31:0] dout_leaf_interface2user_1;
    logic        vld_interface2user_1;
    logic        ack_user2interface_1;

    logic [31:0] din_leaf_user2interface_1;
    logic [31:0] din_leaf_user2interface_2;
    logic        vld_user2interface_1;
    logic        vld_user2interface_2;
    logic        ack_interface2user_1;
    logic        ack_interface2user_2;

    logic [leaf_pkg::NUM_OUT_PORTS-1:0][bft_pkg::NUM_LEAF_BITS-1:0] out_dst_leaf;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0][bft_pkg::NUM_PORT_BITS-1:0] out_dst_port;

    leaf_rx #(
        .LEAF_ID    (LEAF_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) leaf_rx_inst (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .din_leaf_bft2interface     (din_leaf_bft2interface),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .vld_interface2user_1       (vld_interface2user_1),
        .ack_user2interface_1       (ack_user2interface_1),
        .out_dst_leaf               (out_dst_leaf),
        .out_dst_port               (out_dst_port)
    );

    user_kernel #(
        .GROUP_SIZE (GROUP_SIZE)
    ) user_kernel_inst (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .vld_interface2user_1       (vld_interface2user_1),
        .ack_user2interface_1       (ack_user2interface_1),
        .din_leaf_user2interface_1  (din_leaf_user2interface_1),
        .din_leaf_user2interface_2  (din_leaf_user2interface_2),
        .vld_user2interface_1       (vld_user2interface_1),
        .vld_user2interface_2       (vld_user2interface_2),
        .ack_interface2user_1       (ack_interface2user_1),
        .ack_interface2user_2       (ack_interface2user_2)
    );

    leaf_tx #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) leaf_tx_inst (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .resend                    (resend),
        .din_leaf_user2interface_1 (din_leaf_user2interface_1),
        .din_leaf_user2interface_2 (din_leaf_user2interface_2),
        .vld_user2interface_1      (vld_user2interface_1),
        .vld_user2interface_2      (vld_user2interface_2),
        .ack_interface2user_1      (ack_interface2user_1),
        .ack_interface2user_2      (ack_interface2user_2),
        .out_dst_leaf              (out_dst_leaf),
        .out_dst_port              (out_dst_port),
        .dout_leaf_interface2bft   (dout_leaf_interface2bft)
    );

endmodule

// File: verilog/leaf_pkg.sv
package leaf_pkg;

    // port numbering on the leaf.
    localparam logic [bft_pkg::NUM_PORT_BITS-1:0] CFG_PORT  = 4'd0;
    localparam logic [bft_pkg::NUM_PORT_BITS-1:0] IN_PORT_1 = 4'd2;
    localparam int NUM_OUT_PORTS = 2;

    // destination of every output after reset.
    localparam logic [bft_pkg::NUM_LEAF_BITS-1:0] DEFAULT_LEAF = 5'd0;
    localparam logic [bft_pkg::NUM_PORT_BITS-1:0] DEFAULT_PORT = 4'd2;

    // field positions inside the 32-bit configuration word.
    localparam int CFG_PORT_LSB = 0;
    localparam int CFG_LEAF_LSB = CFG_PORT_LSB + bft_pkg::NUM_PORT_BITS;
    localparam int CFG_SEL_LSB  = CFG_LEAF_LSB + bft_pkg::NUM_LEAF_BITS;
    localparam int CFG_SEL_BITS = 4;

endpackage

// File: verilog/leaf_rx.sv
`timescale 1ns/10ps
module leaf_rx #(
    parameter int LEAF_ID    = 5,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  bft_pkg::packet_t                     din_leaf_bft2interface,
    output logic [bft_pkg::PAYLOAD_BITS-1:0]     dout_leaf_interface2user_1,
    output logic                                 vld_interface2user_1,
    input  logic                                 ack_user2interface_1,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0][bft_pkg::NUM_LEAF_BITS-1:0] out_dst_leaf,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0][bft_pkg::NUM_PORT_BITS-1:0] out_dst_port
);

    logic                                for_me;
    logic                                is_cfg;
    logic                                is_data;
    logic [leaf_pkg::CFG_SEL_BITS-1:0]   cfg_sel;
    logic [bft_pkg::NUM_LEAF_BITS-1:0]   cfg_leaf;
    logic [bft_pkg::NUM_PORT_BITS-1:0]   cfg_port;
    logic                                q_full;
    logic                                q_empty;

    assign for_me = din_leaf_bft2interface.data.valid &&
                    (din_leaf_bft2interface.data.dst_leaf ==
                     LEAF_ID[bft_pkg::NUM_LEAF_BITS-1:0]);

    // the same word is looked at as configuration and as data.
    assign is_cfg  = for_me && (din_leaf_bft2interface.cfg.dst_port == leaf_pkg::CFG_PORT);
    assign is_data = for_me && (din_leaf_bft2interface.data.dst_port == leaf_pkg::IN_PORT_1);

    assign cfg_sel  = din_leaf_bft2interface.cfg.cfg[leaf_pkg::CFG_SEL_LSB +:
                                                     leaf_pkg::CFG_SEL_BITS];
    assign cfg_leaf = din_leaf_bft2interface.cfg.cfg[leaf_pkg::CFG_LEAF_LSB +:
                                                     bft_pkg::NUM_LEAF_BITS];
    assign cfg_port = din_leaf_bft2interface.cfg.cfg[leaf_pkg::CFG_PORT_LSB +:
                                                     bft_pkg::NUM_PORT_BITS];

    // destination table, one entry per output.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
                out_dst_leaf[i] <= leaf_pkg::DEFAULT_LEAF;
                out_dst_port[i] <= leaf_pkg::DEFAULT_PORT;
            end
        end else if (is_cfg) begin
            for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
                if (int'(cfg_sel) == i) begin
                    out_dst_leaf[i] <= cfg_leaf;
                    out_dst_port[i] <= cfg_port;
                end
            end
        end
    end

    // data words that find the queue full are lost.
    sync_fifo #(
        .WIDTH (bft_pkg::PAYLOAD_BITS),
        .DEPTH (FIFO_DEPTH)
    ) in_q_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (is_data && !q_full),
        .wr_data (din_leaf_bft2interface.data.payload),
        .full    (q_full),
        .rd_en   (ack_user2interface_1),
        .rd_data (dout_leaf_interface2user_1),
        .empty   (q_empty)
    );

    assign vld_interface2user_1 = !q_empty;

    a_cfg_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        is_cfg |-> (int'(cfg_sel) < leaf_pkg::NUM_OUT_PORTS));

endmodule

// File: verilog/leaf_tx.sv
`timescale 1ns/10ps
module leaf_tx #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                resend,
    input  logic [bft_pkg::PAYLOAD_BITS-1:0]    din_leaf_user2interface_1,
    input  logic [bft_pkg::PAYLOAD_BITS-1:0]    din_leaf_user2interface_2,
    input  logic                                vld_user2interface_1,
    input  logic                                vld_user2interface_2,
    output logic                                ack_interface2user_1,
    output logic                                ack_interface2user_2,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][bft_pkg::NUM_LEAF_BITS-1:0] out_dst_leaf,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][bft_pkg::NUM_PORT_BITS-1:0] out_dst_port,
    output bft_pkg::packet_t                    dout_leaf_interface2bft
);

    logic [1:0][bft_pkg::PAYLOAD_BITS-1:0]  q_wdata;
    logic [1:0][bft_pkg::PAYLOAD_BITS-1:0]  q_rdata;
    logic [1:0][bft_pkg::NUM_ADDR_BITS-1:0] addr_cnt;
    logic [1:0]                             vld_in;
    logic [1:0]                             q_wr;
    logic [1:0]                             q_rd;
    logic [1:0]                             q_full;
    logic [1:0]                             q_empty;
    logic                                   last_sel;
    logic                                   sel;
    logic                                   send;
    bft_pkg::packet_t                       pkt_next;
    bft_pkg::packet_t                       pkt_q;

    assign q_wdata = {din_leaf_user2interface_2, din_leaf_user2interface_1};
    assign vld_in  = {vld_user2interface_2, vld_user2interface_1};
    assign q_wr    = vld_in & ~q_full;

    assign ack_interface2user_1 = !q_full[0];
    assign ack_interface2user_2 = !q_full[1];

    for (genvar g = 0; g < 2; g++) begin : g_out_q
        sync_fifo #(
            .WIDTH (bft_pkg::PAYLOAD_BITS),
            .DEPTH (FIFO_DEPTH)
        ) out_q_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (q_wr[g]),
            .wr_data (q_wdata[g]),
            .full    (q_full[g]),
            .rd_en   (q_rd[g]),
            .rd_data (q_rdata[g]),
            .empty   (q_empty[g])
        );
    end

    // round robin, the queue not served last wins a tie.
    always_comb begin
        if (!q_empty[0] && !q_empty[1]) begin
            sel = !last_sel;
        end else begin
            sel = q_empty[0];
        end
        send = !resend && (q_empty != 2'b11);
        q_rd = '0;
        if (send) begin
            q_rd[sel] = 1'b1;
        end
        pkt_next.data.valid    = 1'b1;
        pkt_next.data.dst_leaf = out_dst_leaf[sel];
        pkt_next.data.dst_port = out_dst_port[sel];
        pkt_next.data.addr     = addr_cnt[sel];
        pkt_next.data.payload  = q_rdata[sel];
    end

    // while resend is high the packet register keeps an unseen packet.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_q    <= '0;
            last_sel <= 1'b1;
            addr_cnt <= '0;
        end else if (!resend) begin
            pkt_q <= send ? pkt_next : '0;
            if (send) begin
                last_sel      <= sel;
                addr_cnt[sel] <= addr_cnt[sel] + 1'b1;
            end
        end
    end

    assign dout_leaf_interface2bft = resend ? '0 : pkt_q;

    // a queue that is not read keeps its head word.
    a_hold_on_resend: assert property (@(posedge clk) disable iff (!rst_n)
        resend |=> $stable(pkt_q) &&
                   ($past(q_empty[0]) || $stable(q_rdata[0])) &&
                   ($past(q_empty[1]) || $stable(q_rdata[1])));

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/10ps
module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;

    // pointers wrap at DEPTH, which need not be a power of two.
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == COUNT_BITS'(DEPTH));

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty));

endmodule

// File: verilog/user_kernel.sv
`timescale 1ns/10ps
module user_kernel #(
    parameter int GROUP_SIZE = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] dout_leaf_interface2user_1,
    input  logic        vld_interface2user_1,
    output logic        ack_user2interface_1,
    output logic [31:0] din_leaf_user2interface_1,
    output logic [31:0] din_leaf_user2interface_2,
    output logic        vld_user2interface_1,
    output logic        vld_user2interface_2,
    input  logic        ack_interface2user_1,
    input  logic        ack_interface2user_2
);

    localparam int CNT_BITS = (GROUP_SIZE > 1) ? $clog2(GROUP_SIZE) : 1;

    logic [31:0]         acc;
    logic [CNT_BITS-1:0] grp_cnt;
    logic                take;
    logic                last_of_group;
    logic [31:0]         swapped;

    // take a word only if both result registers can accept it.
    assign take = vld_interface2user_1 &&
                  (!vld_user2interface_1 || ack_interface2user_1) &&
                  (!vld_user2interface_2 || ack_interface2user_2);
    assign ack_user2interface_1 = take;

    assign last_of_group = (grp_cnt == CNT_BITS'(GROUP_SIZE - 1));
    assign swapped = {dout_leaf_interface2user_1[7:0], dout_leaf_interface2user_1[15:8],
                      dout_leaf_interface2user_1[23:16], dout_leaf_interface2user_1[31:24]};

    always_ff @(posedge clk) begin
        if (take) begin
            din_leaf_user2interface_1 <= swapped;
        end
        if (take && last_of_group) begin
            din_leaf_user2interface_2 <= acc + dout_leaf_interface2user_1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_user2interface_1 <= 1'b0;
            vld_user2interface_2 <= 1'b0;
            acc                  <= '0;
            grp_cnt              <= '0;
        end else begin
            if (ack_interface2user_1) begin
                vld_user2interface_1 <= 1'b0;
            end
            if (ack_interface2user_2) begin
                vld_user2interface_2 <= 1'b0;
            end
            if (take) begin
                vld_user2interface_1 <= 1'b1;
                if (last_of_group) begin
                    vld_user2interface_2 <= 1'b1;
                    acc                  <= '0;
                    grp_cnt              <= '0;
                end else begin
                    acc     <= acc + dout_leaf_interface2user_1;
                    grp_cnt <= grp_cnt + 1'b1;
                end
            end
        end
    end

    // a result waits unchanged until the transmit side takes it.
    a_result_1_held: assert property (@(posedge clk) disable iff (!rst_n)
        vld_user2interface_1 && !ack_interface2user_1 |=>
            vld_user2interface_1 && $stable(din_leaf_user2interface_1));
    a_result_2_held: assert property (@(posedge clk) disable iff (!rst_n)
        vld_user2interface_2 && !ack_interface2user_2 |=>
            vld_user2interface_2 && $stable(din_leaf_user2interface_2));

endmodule
